/* hw/decCodes.svh */
`ifndef DEC_CODES_SVH
`define DEC_CODES_SVH

// micro-commands, low bits of the ALU codes follow the F0 sub-op
typedef enum logic [7:0] {
	UcmdInvop = 8'h00,
	// register to memory stores
	UcmdMovbRm = 8'h01, UcmdMovwRm = 8'h02, UcmdMovlRm = 8'h03, UcmdMovqRm = 8'h04,
	// memory to register loads
	UcmdMovbMr = 8'h05, UcmdMovwMr = 8'h06, UcmdMovlMr = 8'h07, UcmdMovqMr = 8'h08,
	UcmdMovubMr = 8'h09, UcmdMovuwMr = 8'h0A, UcmdMovulMr = 8'h0B,
	UcmdAluAdd3 = 8'h10, UcmdAluSub3 = 8'h11, UcmdAluMul3 = 8'h12,
	UcmdAluAnd3 = 8'h15, UcmdAluOr3 = 8'h16, UcmdAluXor3 = 8'h17,
	UcmdMovIr = 8'h20, UcmdAluLdish16 = 8'h21,
	UcmdCfBra = 8'h30, UcmdCfBsr = 8'h31, UcmdCfBt = 8'h32, UcmdCfBf = 8'h33
} ucmdT;

// operand form ids
typedef enum logic [4:0] {
	FmidInv = 5'h00,
	FmidRegReg = 5'h01,
	FmidRegStReg = 5'h02,
	FmidLdRegReg = 5'h03,
	FmidRegStDrReg = 5'h04,
	FmidLdDrRegReg = 5'h05,
	FmidImm8Reg = 5'h06,
	FmidPcDisp8 = 5'h07
} fmidT;

// immediate types, S signed, U zero, N one extended
typedef enum logic [3:0] {
	ItySw = 4'h1, ItyUb = 4'h4, ItyUw = 4'h5, ItyNw = 4'h9
} ityT;

// access size
typedef enum logic [2:0] {
	BtySb = 3'h0, BtySw = 3'h1, BtySl = 3'h2, BtySq = 3'h3
} btyT;

// address index mode
typedef enum logic [3:0] {
	IxtReg = 4'h0, IxtRdi = 4'h1, IxtRri = 4'h2, IxtRdl = 4'h3
} ixtT;

// general registers are {2'b00, e, nibble}
typedef logic [RegIdW-1:0] regIdT;

localparam regIdT RegPc = 7'h60;
localparam regIdT RegDlr = 7'h61;
localparam regIdT RegImm = 7'h7E;
localparam regIdT RegZzr = 7'h7F;

`endif

/* hw/decPkg.sv */
package decPkg;

	// widths
	localparam int InstrW = 48;
	localparam int RegIdW = 7;
	localparam int ImmW = 33;
	localparam int NibW = 4;

	`include "decCodes.svh"

	// nibble positions of the register fields
	localparam int OLsb = 0;
	localparam int MLsb = 16;
	localparam int NLsb = 20;

	// E-bits extending O, M and N, plus the Q modifier
	localparam int ExIBit = 4;
	localparam int ExMBit = 5;
	localparam int ExNBit = 6;
	localparam int ExQBit = 7;

	// block select nibble
	localparam int BlkLsb = 8;

	// F8 form select, bits 7:5
	localparam int F8SelLsb = 5;

	// F0 sub-op byte
	localparam int SubOpLsb = 24;

	// 16-bit immediate of the F8 forms
	localparam int Imm16Lsb = 16;

	// result of the class stage
	typedef struct packed {
		ucmdT ucmd;
		fmidT fmid;
		ityT ity;
		btyT bty;
		logic exQ;
	} opClassT;

	// index mode, load flag and access size
	typedef struct packed {
		ixtT ixt;
		logic load;
		btyT bty;
	} uixtT;

	// decoded operation
	typedef struct packed {
		regIdT regN;
		regIdT regM;
		regIdT regO;
		logic [ImmW-1:0] imm;
		ucmdT ucmd;
		uixtT uixt;
	} decOpT;

endpackage

/* hw/decOpClass.sv */
module decOpClass import decPkg::*; (
	input logic clock,
	input logic rst,
	input logic istrValid,
	input logic [InstrW-1:0] istrWord,
	output logic clsValid,
	output opClassT cls,
	output logic [InstrW-1:0] clsWord
);

	logic [7:0] subOp;
	logic exQ;
	btyT memBty;
	ucmdT stCmd;
	ucmdT ldCmd;
	opClassT clsNext;

	assign subOp = istrWord[SubOpLsb +: 8];
	assign exQ = istrWord[ExQBit];

	// size from the low two sub-op bits, no unsigned quad load
	always_comb begin
		case (subOp[1:0])
			2'd0: begin
				memBty = BtySb;
				stCmd = UcmdMovbRm;
				ldCmd = exQ ? UcmdMovubMr : UcmdMovbMr;
			end
			2'd1: begin
				memBty = BtySw;
				stCmd = UcmdMovwRm;
				ldCmd = exQ ? UcmdMovuwMr : UcmdMovwMr;
			end
			2'd2: begin
				memBty = BtySl;
				stCmd = UcmdMovlRm;
				ldCmd = exQ ? UcmdMovulMr : UcmdMovlMr;
			end
			default: begin
				memBty = BtySq;
				stCmd = UcmdMovqRm;
				ldCmd = UcmdMovqMr;
			end
		endcase
	end

	always_comb begin
		clsNext.ucmd = UcmdInvop;
		clsNext.fmid = FmidInv;
		clsNext.ity = ItyUb;
		clsNext.bty = BtySb;
		clsNext.exQ = exQ;

		case (istrWord[BlkLsb +: NibW])
			4'h0: begin
				case (subOp[7:4])
					// bit 3 picks load, bit 2 the register index form
					4'h0: begin
						clsNext.bty = memBty;
						if (subOp[3]) begin
							clsNext.ucmd = ldCmd;
							clsNext.fmid = subOp[2] ? FmidLdDrRegReg : FmidLdRegReg;
						end else begin
							clsNext.ucmd = stCmd;
							clsNext.fmid = subOp[2] ? FmidRegStDrReg : FmidRegStReg;
						end
					end
					4'h1: begin
						case (subOp[3:0])
							4'h0: clsNext.ucmd = UcmdAluAdd3;
							4'h1: clsNext.ucmd = UcmdAluSub3;
							4'h2: clsNext.ucmd = UcmdAluMul3;
							4'h5: clsNext.ucmd = UcmdAluAnd3;
							4'h6: clsNext.ucmd = UcmdAluOr3;
							4'h7: clsNext.ucmd = UcmdAluXor3;
							default: clsNext.ucmd = UcmdInvop;
						endcase
						if (clsNext.ucmd != UcmdInvop) begin
							clsNext.fmid = FmidRegReg;
						end
					end
					// pc-relative branches 20..23
					4'h2: begin
						if (subOp[3:2] == 2'b00) begin
							clsNext.fmid = FmidPcDisp8;
							clsNext.bty = BtySw;
							case (subOp[1:0])
								2'd0: clsNext.ucmd = UcmdCfBra;
								2'd1: clsNext.ucmd = UcmdCfBsr;
								2'd2: clsNext.ucmd = UcmdCfBt;
								default: clsNext.ucmd = UcmdCfBf;
							endcase
						end
					end
					default: begin
					end
				endcase
			end
			4'h8: begin
				clsNext.fmid = FmidImm8Reg;
				case (istrWord[F8SelLsb +: 3])
					3'd0: begin
						clsNext.ucmd = UcmdMovIr;
						clsNext.ity = ItyUw;
					end
					3'd1: begin
						clsNext.ucmd = UcmdMovIr;
						clsNext.ity = ItyNw;
					end
					3'd2: begin
						clsNext.ucmd = UcmdAluAdd3;
						clsNext.ity = ItySw;
					end
					3'd3: begin
						clsNext.ucmd = UcmdAluLdish16;
						clsNext.ity = ItyUw;
					end
					default: begin
						clsNext.fmid = FmidInv;
					end
				endcase
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			clsValid <= 1'b0;
		end else begin
			clsValid <= istrValid;
		end
	end

	// payload only moves with a strobe
	always_ff @(posedge clock) begin
		if (istrValid) begin
			cls <= clsNext;
			clsWord <= istrWord;
		end
	end

	clsFollowsStrobe: assert property (@(posedge clock) disable iff (rst)
		clsValid |-> $past(istrValid));

endmodule

/* hw/decOperandForm.sv */
module decOperandForm import decPkg::*; (
	input logic clock,
	input logic rst,
	input logic clsValid,
	input opClassT cls,
	input logic [InstrW-1:0] clsWord,
	output logic opValid,
	output decOpT decOp
);

	regIdT regNDfl;
	regIdT regMDfl;
	regIdT regODfl;
	logic [15:0] imm16;
	logic [ImmW-1:0] immU5;
	logic [ImmW-1:0] immUw;
	logic [ImmW-1:0] immNw;
	logic [ImmW-1:0] immSw;
	logic [ImmW-1:0] immDisp;
	logic isLoad;
	decOpT opNext;

	// default register fields
	assign regNDfl = {2'b00, clsWord[ExNBit], clsWord[NLsb +: NibW]};
	assign regMDfl = {2'b00, clsWord[ExMBit], clsWord[MLsb +: NibW]};
	assign regODfl = {2'b00, clsWord[ExIBit], clsWord[OLsb +: NibW]};

	// imm5 overlays the O field and its E-bit
	assign immU5 = {{(ImmW - 5){1'b0}}, clsWord[ExIBit], clsWord[OLsb +: NibW]};

	assign imm16 = clsWord[Imm16Lsb +: 16];
	assign immUw = {{(ImmW - 16){1'b0}}, imm16};
	assign immNw = {{(ImmW - 16){1'b1}}, imm16};
	assign immSw = {{(ImmW - 16){imm16[15]}}, imm16};

	// branch displacement is bits 7:0 over bits 23:16, signed from bit 7
	assign immDisp = {{(ImmW - 16){clsWord[ExQBit]}}, clsWord[ExQBit -: 8], clsWord[MLsb +: 8]};

	assign isLoad = (cls.fmid == FmidLdRegReg) || (cls.fmid == FmidLdDrRegReg);

	always_comb begin
		opNext.regN = RegZzr;
		opNext.regM = RegZzr;
		opNext.regO = RegZzr;
		opNext.imm = '0;
		opNext.ucmd = cls.ucmd;
		// all zero unless the form sets an index mode
		opNext.uixt = '{ixt: IxtReg, load: 1'b0, bty: BtySb};

		case (cls.fmid)
			FmidRegReg: begin
				opNext.regN = regNDfl;
				opNext.regM = regMDfl;
				opNext.regO = cls.exQ ? RegImm : regODfl;
				opNext.imm = immU5;
			end
			// base plus 5-bit displacement
			FmidRegStReg, FmidLdRegReg: begin
				opNext.regN = regNDfl;
				opNext.regM = regMDfl;
				opNext.imm = immU5;
				opNext.uixt = '{ixt: IxtRdi, load: isLoad, bty: cls.bty};
			end
			// base plus scaled index register
			FmidRegStDrReg, FmidLdDrRegReg: begin
				opNext.regN = regNDfl;
				opNext.regM = regMDfl;
				opNext.regO = regODfl;
				opNext.uixt = '{ixt: IxtRri, load: isLoad, bty: cls.bty};
			end
			FmidImm8Reg: begin
				opNext.regN = regODfl;
				opNext.regM = RegImm;
				opNext.regO = regODfl;
				case (cls.ity)
					ItyNw: opNext.imm = immNw;
					ItySw: opNext.imm = immSw;
					default: opNext.imm = immUw;
				endcase
			end
			FmidPcDisp8: begin
				opNext.regN = RegDlr;
				opNext.regM = RegPc;
				opNext.imm = immDisp;
				opNext.uixt = '{ixt: IxtRdi, load: 1'b1, bty: BtySw};
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			opValid <= 1'b0;
		end else begin
			opValid <= clsValid;
		end
	end

	always_ff @(posedge clock) begin
		if (clsValid) begin
			decOp <= opNext;
		end
	end

	// the class stage pairs Invop with FmidInv only
	invopSelectorsZzr: assert property (@(posedge clock) disable iff (rst)
		opValid && decOp.ucmd == UcmdInvop |->
			decOp.regN == RegZzr && decOp.regM == RegZzr && decOp.regO == RegZzr);

endmodule

/* hw/decOpFx.sv */
module decOpFx import decPkg::*; (
	input logic clock,
	input logic rst,
	input logic istrValid,
	input logic [InstrW-1:0] istrWord,
	output logic opValid,
	output decOpT decOp
);

	logic clsValid;
	opClassT cls;
	logic [InstrW-1:0] clsWord;

	// stage 1, command class
	decOpClass uOpClass (
		.clock(clock),
		.rst(rst),
		.istrValid(istrValid),
		.istrWord(istrWord),
		.clsValid(clsValid),
		.cls(cls),
		.clsWord(clsWord)
	);

	// stage 2, registers and immediate
	decOperandForm uOperandForm (
		.clock(clock),
		.rst(rst),
		.clsValid(clsValid),
		.cls(cls),
		.clsWord(clsWord),
		.opValid(opValid),
		.decOp(decOp)
	);

endmodule

/* verif/tbDecModel.svh */
`ifndef TB_DEC_MODEL_SVH
`define TB_DEC_MODEL_SVH

// 32-bit LCG
function automatic logic [31:0] lcgNext();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return lcgState;
endfunction

function automatic logic [InstrW-1:0] randWord();
	logic [31:0] hi;
	logic [31:0] lo;
	hi = lcgNext();
	lo = lcgNext();
	return {hi, lo[31:16]};
endfunction

// expected decode of one word
function automatic decOpT expectOp(input logic [InstrW-1:0] w);
	decOpT e;
	logic [7:0] sub;
	regIdT fo;
	btyT sz;
	sub = w[31:24];
	fo = {2'b00, w[4], w[3:0]};
	sz = btyT'(sub[1:0]);
	e = '0;
	e.regN = RegZzr;
	e.regM = RegZzr;
	e.regO = RegZzr;
	e.ucmd = UcmdInvop;
	if (w[11:8] == 4'h0 && sub[7:4] == 4'h0) begin
		e.regN = {2'b00, w[6], w[23:20]};
		e.regM = {2'b00, w[5], w[19:16]};
		case ({sub[3], sub[1:0]})
			3'b000: e.ucmd = UcmdMovbRm;
			3'b001: e.ucmd = UcmdMovwRm;
			3'b010: e.ucmd = UcmdMovlRm;
			3'b011: e.ucmd = UcmdMovqRm;
			3'b100: e.ucmd = w[7] ? UcmdMovubMr : UcmdMovbMr;
			3'b101: e.ucmd = w[7] ? UcmdMovuwMr : UcmdMovwMr;
			3'b110: e.ucmd = w[7] ? UcmdMovulMr : UcmdMovlMr;
			default: e.ucmd = UcmdMovqMr;
		endcase
		// bit 2 selects the index register form
		if (sub[2]) begin
			e.regO = fo;
			e.uixt = '{ixt: IxtRri, load: sub[3], bty: sz};
		end else begin
			e.imm = {28'd0, w[4:0]};
			e.uixt = '{ixt: IxtRdi, load: sub[3], bty: sz};
		end
	end else if (w[11:8] == 4'h0 && sub[7:4] == 4'h1) begin
		case (sub[3:0])
			4'h0: e.ucmd = UcmdAluAdd3;
			4'h1: e.ucmd = UcmdAluSub3;
			4'h2: e.ucmd = UcmdAluMul3;
			4'h5: e.ucmd = UcmdAluAnd3;
			4'h6: e.ucmd = UcmdAluOr3;
			4'h7: e.ucmd = UcmdAluXor3;
			default: e.ucmd = UcmdInvop;
		endcase
		if (e.ucmd != UcmdInvop) begin
			e.regN = {2'b00, w[6], w[23:20]};
			e.regM = {2'b00, w[5], w[19:16]};
			e.regO = w[7] ? RegImm : fo;
			e.imm = {28'd0, w[4:0]};
		end
	end else if (w[11:8] == 4'h0 && sub[7:2] == 6'b001000) begin
		case (sub[1:0])
			2'd0: e.ucmd = UcmdCfBra;
			2'd1: e.ucmd = UcmdCfBsr;
			2'd2: e.ucmd = UcmdCfBt;
			default: e.ucmd = UcmdCfBf;
		endcase
		e.regN = RegDlr;
		e.regM = RegPc;
		e.imm = {{17{w[7]}}, w[7:0], w[23:16]};
		e.uixt = '{ixt: IxtRdi, load: 1'b1, bty: BtySw};
	end else if (w[11:8] == 4'h8 && w[7:5] < 3'd4) begin
		e.regN = fo;
		e.regM = RegImm;
		e.regO = fo;
		case (w[7:5])
			3'd0: e.ucmd = UcmdMovIr;
			3'd1: e.ucmd = UcmdMovIr;
			3'd2: e.ucmd = UcmdAluAdd3;
			default: e.ucmd = UcmdAluLdish16;
		endcase
		if (w[7:5] == 3'd1) begin
			e.imm = {{17{1'b1}}, w[31:16]};
		end else if (w[7:5] == 3'd2) begin
			e.imm = {{17{w[31]}}, w[31:16]};
		end else begin
			e.imm = {17'd0, w[31:16]};
		end
	end
	return e;
endfunction

task automatic reportField(input string name, input logic [ImmW-1:0] got,
		input logic [ImmW-1:0] exp);
	$display("Fail %s got %h expected %h", name, got, exp);
	valueErrors++;
endtask

task automatic checkDecOp(input decOpT got, input decOpT exp);
	if (got.regN !== exp.regN) reportField("decOp.regN", got.regN, exp.regN);
	if (got.regM !== exp.regM) reportField("decOp.regM", got.regM, exp.regM);
	if (got.regO !== exp.regO) reportField("decOp.regO", got.regO, exp.regO);
	if (got.imm !== exp.imm) reportField("decOp.imm", got.imm, exp.imm);
	if (got.ucmd !== exp.ucmd) reportField("decOp.ucmd", got.ucmd, exp.ucmd);
	if (got.uixt !== exp.uixt) reportField("decOp.uixt", got.uixt, exp.uixt);
endtask

task automatic checkValid(input logic got, input logic exp);
	if (got !== exp) begin
		if (exp) begin
			$display("a strobed word produced no result");
		end else begin
			$display("a result appeared with no word in flight");
		end
		protocolErrors++;
	end
endtask

`endif

/* verif/tbDecOpFx.sv */
module tbDecOpFx import decPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic clock;
	logic rst;
	logic istrValid;
	logic [InstrW-1:0] istrWord;
	logic opValid;
	decOpT decOp;
	int valueErrors;
	int protocolErrors;
	logic [31:0] lcgState;

	`include "tbDecModel.svh"

	decOpFx DUT (
		.clock(clock),
		.rst(rst),
		.istrValid(istrValid),
		.istrWord(istrWord),
		.opValid(opValid),
		.decOp(decOp)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// one strobe, result expected two edges later
	task automatic applyWord(input logic [InstrW-1:0] w);
		int waited;
		@(posedge clock);
		istrValid <= 1'b1;
		istrWord <= w;
		@(posedge clock);
		istrValid <= 1'b0;
		waited = 1;
		@(negedge clock);
		while (!opValid && waited < 10) begin
			@(negedge clock);
			waited++;
		end
		if (!opValid) begin
			checkValid(opValid, 1'b1);
		end else begin
			if (waited != 2) begin
				$display("result for word %h came after %0d cycles instead of 2", w, waited);
				protocolErrors++;
			end
			checkDecOp(decOp, expectOp(w));
		end
	endtask

	task automatic testIdle();
		repeat (20) begin
			@(negedge clock);
			checkValid(opValid, 1'b0);
		end
	endtask

	// all 16 memory sub-ops, signed and unsigned
	task automatic testMemOps();
		logic [InstrW-1:0] w;
		for (int s = 0; s < 16; s++) begin
			for (int q = 0; q < 2; q++) begin
				w = randWord();
				w[11:8] = 4'h0;
				w[31:24] = 8'(s);
				w[7] = q[0];
				applyWord(w);
			end
		end
	endtask

	task automatic testAlu();
		logic [7:0] aluOps [0:5] = '{8'h10, 8'h11, 8'h12, 8'h15, 8'h16, 8'h17};
		logic [InstrW-1:0] w;
		for (int i = 0; i < 6; i++) begin
			for (int q = 0; q < 2; q++) begin
				w = randWord();
				w[11:8] = 4'h0;
				w[31:24] = aluOps[i];
				w[7] = q[0];
				applyWord(w);
			end
		end
	endtask

	// bit 7 is the displacement sign
	task automatic testBranch();
		logic [InstrW-1:0] w;
		for (int b = 0; b < 4; b++) begin
			for (int sgn = 0; sgn < 2; sgn++) begin
				w = randWord();
				w[11:8] = 4'h0;
				w[31:24] = 8'h20 + 8'(b);
				w[7] = sgn[0];
				applyWord(w);
			end
		end
	endtask

	task automatic testImm16();
		logic [InstrW-1:0] w;
		for (int f = 0; f < 4; f++) begin
			for (int sgn = 0; sgn < 2; sgn++) begin
				w = randWord();
				w[11:8] = 4'h8;
				w[7:5] = 3'(f);
				w[31] = sgn[0];
				applyWord(w);
			end
		end
	endtask

	// back to back strobes, results checked in order
	task automatic testStream();
		logic [InstrW-1:0] w;
		logic [31:0] r;
		logic [InstrW-1:0] sentWord[$];
		int sentAt[$];
		int sent;
		int t;
		sent = 0;
		t = 0;
		while ((sent < 200 || sentWord.size() > 0) && t < 230) begin
			@(posedge clock);
			if (sent < 200) begin
				w = randWord();
				r = lcgNext();
				case (r[2:0])
					3'd0, 3'd1: w[31:28] = 4'h0;
					3'd2: w[31:28] = 4'h1;
					3'd3: w[31:28] = 4'h2;
					default: begin
					end
				endcase
				// mostly F0 and F8, the rest random blocks
				if (r[2:0] < 3'd4) begin
					w[11:8] = 4'h0;
				end else if (r[2:0] < 3'd6) begin
					w[11:8] = 4'h8;
				end
				istrValid <= 1'b1;
				istrWord <= w;
				sentWord.push_back(w);
				sentAt.push_back(t);
				sent++;
			end else begin
				istrValid <= 1'b0;
			end
			@(negedge clock);
			if (opValid) begin
				if (sentWord.size() == 0) begin
					checkValid(opValid, 1'b0);
				end else begin
					w = sentWord.pop_front();
					if (t - sentAt.pop_front() != 2) begin
						$display("result for word %h came with the wrong latency", w);
						protocolErrors++;
					end
					checkDecOp(decOp, expectOp(w));
				end
			end
			t++;
		end
		if (sentWord.size() > 0) begin
			$display("%0d strobed words produced no result", sentWord.size());
			protocolErrors++;
		end
		@(posedge clock);
		istrValid <= 1'b0;
	endtask

	initial begin
		rst = 1'b1;
		istrValid = 1'b0;
		istrWord = '0;
		lcgState = 32'd21;
		valueErrors = 0;
		protocolErrors = 0;
		repeat (16) @(posedge clock);
		rst <= 1'b0;
		testIdle();
		testMemOps();
		testAlu();
		testBranch();
		testImm16();
		testStream();
		$display("value errors %0d, protocol errors %0d", valueErrors, protocolErrors);
		if (valueErrors + protocolErrors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+hw
+incdir+verif
hw/decPkg.sv
hw/decOpClass.sv
hw/decOperandForm.sv
hw/decOpFx.sv
verif/tbDecOpFx.sv
